/* design/mem_pkg.sv */
package mem_pkg;

    // Width of one stored word
    localparam int WORD_WIDTH = 36;

    // Each word travels as two halves
    localparam int NIBBLE_WIDTH = WORD_WIDTH / 2;

    // Full memory word
    typedef logic [WORD_WIDTH-1:0] mem_word_t;

    // One half of a memory word, upper or lower
    typedef logic [NIBBLE_WIDTH-1:0] mem_half_t;

    // Write request toward the memory
    // Enable and data are sampled on the same edge
    typedef struct packed {
        logic      enable;
        mem_word_t data;
    } mem_write_t;

endpackage

/* design/link_pkg.sv */
package link_pkg;

    import mem_pkg::*;

    // Marker bits in front of each half
    localparam int MARK_WIDTH = 2;

    // One framed half is a marker plus a memory half word
    localparam int HALF_SIZE = NIBBLE_WIDTH + MARK_WIDTH;

    // Whole serial packet, two framed halves
    localparam int PACKET_SIZE = 2 * HALF_SIZE;

    // Marker sent before the upper half
    localparam logic [MARK_WIDTH-1:0] MARK_UPPER = 2'b01;

    // Marker sent before the lower half
    localparam logic [MARK_WIDTH-1:0] MARK_LOWER = 2'b10;

    // One half as it appears on the line, marker first
    typedef struct packed {
        logic [MARK_WIDTH-1:0] marker;
        mem_half_t             half;
    } link_half_t;

    // Framed view of a packet, upper half goes out first
    typedef struct packed {
        link_half_t upper;
        link_half_t lower;
    } link_frame_t;

    // Same 40 bits seen two ways
    // raw is the shift view, framed is the field view
    typedef union packed {
        logic [PACKET_SIZE-1:0] raw;
        link_frame_t            framed;
    } link_packet_u;

endpackage

/* design/packet_rx.sv */
module packet_rx import link_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    // Serial line, one bit per clock
    input  logic         serial_in,

    // Assembled packet toward the memory interface
    output link_packet_u rx_packet,
    output logic         data_ready
);

    localparam int COUNT_WIDTH = $clog2(PACKET_SIZE);

    // Position of the last bit in a packet
    localparam logic [COUNT_WIDTH-1:0] LAST_BIT = COUNT_WIDTH'(PACKET_SIZE - 1);

    // Bits received so far in the current packet
    // Only the first 39 need storage, the last one is taken straight off the line
    logic [PACKET_SIZE-2:0] shift_reg;

    // Bit position inside the packet, counted from the end of reset
    logic [COUNT_WIDTH-1:0] bit_count;

    // Framing counter
    // Position 0 is the first clock after reset, which carries the MSB
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_count <= '0;
        end else if (bit_count == LAST_BIT) begin
            bit_count <= '0;
        end else begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // Shift register for the payload
    // Earliest bit ends up at the top
    always_ff @(posedge clk) begin
        shift_reg <= {shift_reg[PACKET_SIZE-3:0], serial_in};
    end

    // Packet boundary
    // The 40th bit is on the line in this cycle, so the packet is complete now
    // Count is held at 0 in reset, which keeps the strobe low there
    assign data_ready = (bit_count == LAST_BIT);

    // Complete packet as seen in the boundary cycle
    // Stored bits on top, current line bit as the LSB
    assign rx_packet.raw = {shift_reg, serial_in};

endmodule

/* design/memif.sv */
module memif import link_pkg::*, mem_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  reset,

    // From the receiver
    input  link_packet_u          rx_packet,
    input  logic                  data_ready,

    // Memory read port
    output logic [ADDR_WIDTH-1:0] rd_addr,
    input  mem_word_t             rd_data,

    // Memory write port
    output logic [ADDR_WIDTH-1:0] wr_addr,
    output mem_write_t            mem_wr,

    // Toward the transmitter
    output mem_word_t             tx_word,
    output logic                  load_output,

    // Framing verdict of the latest packet
    output logic                  valid
);

    // Shared address for the read and write side
    // The word read here is sent out before it gets overwritten
    logic [ADDR_WIDTH-1:0] addr;

    // Both markers in place
    logic frame_ok;

    // Word rebuilt from the two framed halves
    mem_word_t rx_word;

    assign frame_ok = (rx_packet.framed.upper.marker == MARK_UPPER) &&
                      (rx_packet.framed.lower.marker == MARK_LOWER);

    assign rx_word = {rx_packet.framed.upper.half, rx_packet.framed.lower.half};

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            addr <= '0;
            mem_wr.enable <= 1'b0;
            // Keep the transmitter loading the word at address 0
            // so the first packet leaves right after reset
            load_output <= 1'b1;
            valid <= 1'b0;
        end else if (data_ready) begin
            // Boundary: send out the stored word, store the new one if framed
            load_output <= 1'b1;
            mem_wr.enable <= frame_ok;
            valid <= frame_ok;
        end else begin
            load_output <= 1'b0;
            mem_wr.enable <= 1'b0;
            // Step only after a write went in
            // A rejected packet leaves the slot where it is
            if (mem_wr.enable) begin
                addr <= addr + 1'b1;
            end
        end
    end

    // Payload registers
    // Write data is only looked at together with enable
    always_ff @(posedge clk) begin
        mem_wr.data <= rx_word;
        // Latched every clock, the transmitter only takes it on load_output
        tx_word <= rd_data;
    end

    // Reads and writes always use the same entry
    assign rd_addr = addr;
    assign wr_addr = addr;

endmodule

/* design/packet_ram.sv */
module packet_ram import mem_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,

    // Read port, one clock of latency
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output mem_word_t             rd_data,

    // Write port
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  mem_write_t            mem_wr
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Storage array
    // Contents start undefined, the first pass through memory fills it
    mem_word_t mem [DEPTH];

    // Write on the edge where enable is high
    always_ff @(posedge clk) begin
        if (mem_wr.enable) begin
            mem[wr_addr] <= mem_wr.data;
        end
    end

    // Registered read
    // Old data is returned when reading and writing the same entry on one edge
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* design/packet_tx.sv */
module packet_tx import link_pkg::*, mem_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // From the memory interface
    input  mem_word_t tx_word,
    input  logic      load_output,

    // Serial line toward the far end
    output logic      serial_out,
    output logic      frame_start
);

    // Outgoing word with markers put back in
    link_packet_u framed_word;

    // Bits still to be sent, MSB is on the line
    link_packet_u shift_reg;

    // Rebuild the frame
    // 01, upper half, 10, lower half
    always_comb begin
        framed_word.framed.upper.marker = MARK_UPPER;
        framed_word.framed.upper.half = tx_word[WORD_WIDTH-1:NIBBLE_WIDTH];
        framed_word.framed.lower.marker = MARK_LOWER;
        framed_word.framed.lower.half = tx_word[NIBBLE_WIDTH-1:0];
    end

    // Load on the boundary strobe, otherwise shift toward the MSB
    // Zeros fill in behind the last bit
    always_ff @(posedge clk) begin
        if (load_output) begin
            shift_reg.raw <= framed_word.raw;
        end else begin
            shift_reg.raw <= {shift_reg.raw[PACKET_SIZE-2:0], 1'b0};
        end
    end

    // Start marker for the far end
    // High in the cycle that bit 39 is on the line
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= load_output;
        end
    end

    // Top bit of the register goes out
    assign serial_out = shift_reg.raw[PACKET_SIZE-1];

endmodule

/* design/loopback_top.sv */
module loopback_top import link_pkg::*, mem_pkg::*; #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic clk,
    input  logic reset,

    // Serial link
    input  logic serial_in,
    output logic serial_out,
    output logic frame_start,

    // Framing verdict of the latest received packet
    output logic valid
);

    // Receiver to memory interface
    link_packet_u rx_packet;
    logic         data_ready;

    // Memory interface to memory
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [ADDR_WIDTH-1:0] wr_addr;
    mem_word_t             rd_data;
    mem_write_t            mem_wr;

    // Memory interface to transmitter
    mem_word_t tx_word;
    logic      load_output;

    // Deserializer
    packet_rx packet_rx_inst (
        .clk        (clk),
        .reset      (reset),
        .serial_in  (serial_in),
        .rx_packet  (rx_packet),
        .data_ready (data_ready)
    );

    // Framing check and address control
    memif #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) memif_inst (
        .clk         (clk),
        .reset       (reset),
        .rx_packet   (rx_packet),
        .data_ready  (data_ready),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .wr_addr     (wr_addr),
        .mem_wr      (mem_wr),
        .tx_word     (tx_word),
        .load_output (load_output),
        .valid       (valid)
    );

    // Word store
    packet_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) packet_ram_inst (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_addr (wr_addr),
        .mem_wr  (mem_wr)
    );

    // Serializer
    packet_tx packet_tx_inst (
        .clk         (clk),
        .reset       (reset),
        .tx_word     (tx_word),
        .load_output (load_output),
        .serial_out  (serial_out),
        .frame_start (frame_start)
    );

endmodule

/* verification/loopback_props.sv */
module loopback_props import link_pkg::*, mem_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         valid,
    input logic         frame_start,
    input logic         data_ready,
    input link_packet_u rx_packet,
    input mem_write_t   mem_wr
);

    // Markers as the line should carry them, 01 on top and 10 in the middle
    logic      frame_ok;
    mem_word_t rx_payload;

    // Cycles since the last frame start
    logic [5:0] gap;
    logic       seen;

    assign frame_ok = (rx_packet.raw[39:38] == 2'b01) && (rx_packet.raw[19:18] == 2'b10);
    assign rx_payload = {rx_packet.raw[37:20], rx_packet.raw[17:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            gap <= '0;
            seen <= 1'b0;
        end else if (frame_start) begin
            gap <= '0;
            seen <= 1'b1;
        end else begin
            gap <= gap + 1'b1;
        end
    end

    // Verdict and write enable follow the markers of the packet just taken
    verdict_matches_markers: assert property (@(posedge clk) disable iff (reset)
        data_ready |=> (valid == $past(frame_ok)))
        else $error("valid does not match the markers of the received packet");

    write_matches_verdict: assert property (@(posedge clk) disable iff (reset)
        data_ready |=> (mem_wr.enable == $past(frame_ok)))
        else $error("write enable does not match the framing verdict");

    // Written word is the payload of the framed packet
    write_data_matches: assert property (@(posedge clk) disable iff (reset)
        (data_ready && frame_ok) |=> (mem_wr.data == $past(rx_payload)))
        else $error("written word differs from the received payload");

    write_needs_valid: assert property (@(posedge clk) disable iff (reset)
        mem_wr.enable |-> valid)
        else $error("write enable high without a valid verdict");

    // One frame start every 40 cycles
    frame_start_spacing: assert property (@(posedge clk) disable iff (reset)
        (frame_start && seen) |-> (gap == 6'd39))
        else $error("frame_start did not come 40 cycles after the previous one");

    frame_start_single: assert property (@(posedge clk) disable iff (reset)
        frame_start |=> !frame_start)
        else $error("frame_start held for more than one cycle");

    // Reset behavior
    reset_quiet: assert property (@(posedge clk)
        reset |=> (!valid && !frame_start && !mem_wr.enable))
        else $error("valid, frame_start or write enable high during reset");

    first_frame_after_reset: assert property (@(posedge clk)
        $fell(reset) |=> frame_start)
        else $error("first frame_start missing one cycle after reset");

endmodule

bind loopback_top loopback_props loopback_props_inst (
    .clk         (clk),
    .reset       (reset),
    .valid       (valid),
    .frame_start (frame_start),
    .data_ready  (data_ready),
    .rx_packet   (rx_packet),
    .mem_wr      (mem_wr)
);

/* verification/loopback_tb.sv */
module loopback_tb import mem_pkg::*; ();

    localparam int ADDR_WIDTH = 3;
    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int FRAME_BITS = 40;
    localparam int PHASE1_PACKETS = 20;
    localparam int PHASE2_PACKETS = 12;
    localparam int NUM_PACKETS = PHASE1_PACKETS + PHASE2_PACKETS;
    localparam int TIMEOUT = (NUM_PACKETS + 4) * FRAME_BITS * 10;

    logic clk;
    logic reset;
    logic serial_in;
    logic serial_out;
    logic frame_start;
    logic valid;

    // Reference model of the store
    mem_word_t model_mem [DEPTH];
    bit        model_known [DEPTH];
    int        model_addr;

    // Predicted output frames, oldest first
    logic [FRAME_BITS-1:0] expect_q [$];
    bit                    known_q [$];

    int driver_errors;
    int monitor_errors = 0;
    int packets_sent;
    int frames_checked = 0;

    // Output monitor state
    logic [FRAME_BITS-1:0] rx_frame = '0;
    int                    rx_count = 0;
    bit                    collecting = 1'b0;

    loopback_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) loopback_top_inst (
        .clk         (clk),
        .reset       (reset),
        .serial_in   (serial_in),
        .serial_out  (serial_out),
        .frame_start (frame_start),
        .valid       (valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Line format, marker 01, upper half, marker 10, lower half
    function automatic logic [FRAME_BITS-1:0] frame_of(input mem_word_t word);
        return {2'b01, word[WORD_WIDTH-1:NIBBLE_WIDTH], 2'b10, word[NIBBLE_WIDTH-1:0]};
    endfunction

    // Random payload, mis-framed in one of three ways when not good
    function automatic logic [FRAME_BITS-1:0] make_packet(input bit good, input int variant);
        logic [31:0]           r_hi;
        logic [31:0]           r_lo;
        mem_word_t             word;
        logic [FRAME_BITS-1:0] pkt;
        r_hi = $urandom();
        r_lo = $urandom();
        word = {r_hi[3:0], r_lo};
        pkt = frame_of(word);
        if (!good) begin
            case (variant)
                0: pkt[39:38] = 2'b11;
                1: pkt[19:18] = 2'b00;
                default: begin
                    // Markers swapped
                    pkt[39:38] = 2'b10;
                    pkt[19:18] = 2'b01;
                end
            endcase
        end
        return pkt;
    endfunction

    // Called one time unit after a rising edge
    // First packet bit goes on the line together with the reset release
    task automatic apply_reset();
        reset = 1'b1;
        serial_in = 1'b0;
        expect_q.delete();
        known_q.delete();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        model_addr = 0;
        // Word at address 0 is primed out right after reset
        expect_q.push_back(frame_of(model_mem[0]));
        known_q.push_back(model_known[0]);
    endtask

    task automatic send_packet(input logic [FRAME_BITS-1:0] pkt);
        bit        good;
        mem_word_t word;
        good = (pkt[39:38] == 2'b01) && (pkt[19:18] == 2'b10);
        word = {pkt[37:20], pkt[17:0]};
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            serial_in = pkt[i];
            @(posedge clk);
            #1;
        end
        // Verdict is registered on the boundary edge
        assert (valid == good) else begin
            $display("** Error valid expected 0x%h got 0x%h", good, valid);
            driver_errors++;
        end
        // Slot carries the word at the current address, before it is overwritten
        expect_q.push_back(frame_of(model_mem[model_addr]));
        known_q.push_back(model_known[model_addr]);
        if (good) begin
            model_mem[model_addr] = word;
            model_known[model_addr] = 1'b1;
            model_addr = (model_addr + 1) % DEPTH;
        end
        packets_sent++;
    endtask

    // Every sixth packet is mis-framed
    // The kind of framing fault rotates from one bad packet to the next
    task automatic send_packets(input int count);
        for (int i = 0; i < count; i++) begin
            send_packet(make_packet((i % 6) != 3, (i / 6) % 3));
        end
    endtask

    task automatic check_frame(input logic [FRAME_BITS-1:0] frame);
        logic [FRAME_BITS-1:0] expected;
        bit                    known;
        frames_checked++;
        assert (frame[39:38] == 2'b01 && frame[19:18] == 2'b10) else begin
            $display("** Error serial_out markers expected 0x1 0x2 got 0x%h 0x%h",
                     frame[39:38], frame[19:18]);
            monitor_errors++;
        end
        assert (expect_q.size() != 0) else begin
            $display("Output frame arrived with no packet waiting for it");
            monitor_errors++;
        end
        if (expect_q.size() != 0) begin
            expected = expect_q.pop_front();
            known = known_q.pop_front();
            // Unwritten entries carry no known payload
            if (known) begin
                assert (frame == expected) else begin
                    $display("** Error serial_out expected 0x%h got 0x%h", expected, frame);
                    monitor_errors++;
                end
            end
        end
    endtask

    // Collect each outgoing frame from its start pulse, sampled mid cycle
    always @(negedge clk) begin
        if (reset) begin
            collecting = 1'b0;
        end else begin
            if (frame_start) begin
                assert (!collecting) else begin
                    $display("Frame start arrived before the previous frame was complete");
                    monitor_errors++;
                end
                collecting = 1'b1;
                rx_count = 0;
                rx_frame = '0;
            end
            if (collecting) begin
                rx_frame = {rx_frame[FRAME_BITS-2:0], serial_out};
                rx_count++;
                if (rx_count == FRAME_BITS) begin
                    check_frame(rx_frame);
                    collecting = 1'b0;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired before all packets came back");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'he886_9e5e));
        driver_errors = 0;
        packets_sent = 0;
        model_addr = 0;
        for (int i = 0; i < DEPTH; i++) begin
            model_mem[i] = '0;
            model_known[i] = 1'b0;
        end
        reset = 1'b1;
        serial_in = 1'b0;

        apply_reset();
        $display("power_on_reset done, errors %0d", driver_errors + monitor_errors);

        // Fill the store, then echo with skips
        send_packets(PHASE1_PACKETS);
        $display("fill_and_echo done, errors %0d", driver_errors + monitor_errors);

        // One idle cycle so the last full frame is seen before reset cuts in
        serial_in = 1'b0;
        @(posedge clk);
        #1;
        apply_reset();
        send_packets(PHASE2_PACKETS);
        serial_in = 1'b0;
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("mid_run_reset done, errors %0d", driver_errors + monitor_errors);

        $display("Summary: %0d packets sent, %0d frames checked, %0d errors",
                 packets_sent, frames_checked, driver_errors + monitor_errors);
        if (driver_errors + monitor_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
design/mem_pkg.sv
design/link_pkg.sv
design/packet_rx.sv
design/memif.sv
design/packet_ram.sv
design/packet_tx.sv
design/loopback_top.sv
verification/loopback_props.sv
verification/loopback_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the loopback testbench, verdict comes from the log
rm -rf obj_dir sim.log

verilator --binary --assert --top-module loopback_tb -f list.f -o loopback_sim \
    && ./obj_dir/loopback_sim > sim.log 2>&1 \
    || echo "Build or simulation stopped with an error"

cat sim.log 2>/dev/null

grep -q "TEST RESULT: PASS" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
